/* src/bfs_consts.svh */
// ########################################
// Lane count, queue depth and id width
// ########################################
`ifndef BFS_CONSTS_SVH
`define BFS_CONSTS_SVH

`define BFS_NUM_LANES 4
// Rows per lane, one row stays spare to tell full from empty
`define BFS_Q_SIZE    8
`define BFS_VID_W     32

// Derived index widths
`define BFS_LANE_W    ($clog2(`BFS_NUM_LANES))
`define BFS_Q_AW      ($clog2(`BFS_Q_SIZE))

`endif

/* src/bfs_vertex_pkg.sv */
// ########################################
// Vertex id type and frontier row union
// ########################################
`include "bfs_consts.svh"

package bfs_vertex_pkg;

  // One vertex id
  typedef logic [`BFS_VID_W-1:0] vid_t;

  // Two ids of a row, lo is the older entry
  typedef struct packed {
    vid_t hi;
    vid_t lo;
  } vid_pair_t;

  // Queue row seen as one word or as an id pair
  typedef union packed {
    logic [2*`BFS_VID_W-1:0] raw;
    vid_pair_t               pair;
  } frontier_row_u;

endpackage

/* src/bfs_lane_pkg.sv */
// ########################################
// Enqueue row, lane status, drained row
// ########################################
`include "bfs_consts.svh"

package bfs_lane_pkg;

  // Incoming row from the expansion stage
  // req is 01 for one id, 11 for a pair
  typedef struct packed {
    logic [1:0]                   req;
    bfs_vertex_pkg::frontier_row_u row;
  } enq_row_t;

  // Per-lane flags seen by dispatch and drain
  typedef struct packed {
    logic full;
    logic empty;
    logic filled;
    // Dequeue honoured this cycle
    logic taken;
  } lane_status_t;

  // Row leaving the buffer
  typedef struct packed {
    logic [`BFS_LANE_W-1:0]       lane;
    // Number of valid ids, 1 or 2
    logic [1:0]                   count;
    bfs_vertex_pkg::frontier_row_u row;
  } drain_out_t;

endpackage

/* src/queue_out.sv */
// ########################################
// Frontier queue for one lane
// ########################################
`include "bfs_consts.svh"

module queue_out (
  input  logic                          clk,
  input  logic                          bfs_rst,
  input  logic [1:0]                    enqueue_req,
  input  bfs_vertex_pkg::frontier_row_u wdata_in,
  input  logic                          dequeue_req,
  output bfs_vertex_pkg::frontier_row_u rdata_out,
  output bfs_lane_pkg::lane_status_t    status
);

  // Two id slots per row
  bfs_vertex_pkg::vid_t slot0 [`BFS_Q_SIZE];
  bfs_vertex_pkg::vid_t slot1 [`BFS_Q_SIZE];
  logic [`BFS_Q_SIZE-1:0] valid0;
  // Set when both slots hold an id
  logic [`BFS_Q_SIZE-1:0] valid01;

  // Pointers with a polarity bit on top
  logic [`BFS_Q_AW:0]   head_ptr;
  logic [`BFS_Q_AW:0]   tail_ptr;
  logic [`BFS_Q_AW-1:0] head_idx;
  logic [`BFS_Q_AW-1:0] tail_idx;
  logic [`BFS_Q_AW-1:0] tail_idx_inc;

  logic any_req;
  logic pair_req;
  logic tail_half;
  logic head_is_tail;
  logic q_full;
  logic q_empty;
  logic enq_ok;
  logic refuse;
  logic take;
  logic adv_head;
  logic adv_tail;

  assign head_idx     = head_ptr[`BFS_Q_AW-1:0];
  assign tail_idx     = tail_ptr[`BFS_Q_AW-1:0];
  assign tail_idx_inc = tail_idx + 1'b1;

  assign any_req  = |enqueue_req;
  assign pair_req = &enqueue_req;

  // Tail row already has slot 0 taken
  assign tail_half    = valid0[tail_idx];
  assign head_is_tail = (head_ptr == tail_ptr);

  assign q_full  = (tail_idx_inc == head_idx);
  assign q_empty = ~valid0[head_idx];

  assign enq_ok = any_req & ~q_full;

  // Enqueue is completing the half row at the head, so hold the dequeue
  assign refuse = head_is_tail & tail_half & enq_ok;
  assign take   = dequeue_req & ~q_empty & ~refuse;

  // Head only moves past rows that were filled
  assign adv_head = take & valid01[head_idx];
  assign adv_tail = enq_ok & (pair_req | tail_half);

  // Id storage
  always_ff @(posedge clk) begin
    if (enq_ok) begin
      if (tail_half) begin
        slot1[tail_idx] <= wdata_in.pair.lo;
        if (pair_req) begin
          slot0[tail_idx_inc] <= wdata_in.pair.hi;
        end
      end else begin
        slot0[tail_idx] <= wdata_in.pair.lo;
        if (pair_req) begin
          slot1[tail_idx] <= wdata_in.pair.hi;
        end
      end
    end
  end

  // Row valid bits
  always_ff @(posedge clk) begin
    if (bfs_rst) begin
      valid0  <= '0;
      valid01 <= '0;
    end else begin
      // Dequeue drops both slots of the head row
      if (take) begin
        valid0[head_idx]  <= 1'b0;
        valid01[head_idx] <= 1'b0;
      end
      if (enq_ok) begin
        if (tail_half) begin
          valid01[tail_idx] <= 1'b1;
          if (pair_req) begin
            valid0[tail_idx_inc] <= 1'b1;
          end
        end else begin
          valid0[tail_idx] <= 1'b1;
          if (pair_req) begin
            valid01[tail_idx] <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bfs_rst) begin
      head_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      if (adv_head) begin
        head_ptr <= head_ptr + 1'b1;
      end
      if (adv_tail) begin
        tail_ptr <= tail_ptr + 1'b1;
      end
    end
  end

  assign rdata_out.pair = '{hi: slot1[head_idx], lo: slot0[head_idx]};

  assign status = '{full: q_full, empty: q_empty, filled: valid01[head_idx], taken: take};

endmodule

/* src/frontier_dispatch.sv */
// ########################################
// Round-robin lane choice for new rows
// ########################################
`include "bfs_consts.svh"

module frontier_dispatch (
  input  logic                                               clk,
  input  logic                                               bfs_rst,
  input  bfs_lane_pkg::enq_row_t                             enq,
  input  logic [`BFS_NUM_LANES-1:0]                          lane_full,
  output logic [`BFS_NUM_LANES-1:0][1:0]                     lane_enqueue_req,
  output bfs_vertex_pkg::frontier_row_u [`BFS_NUM_LANES-1:0] lane_wdata,
  output logic                                               frontier_full
);

  // Preferred lane for the next row
  logic [`BFS_LANE_W-1:0] ptr;
  logic [`BFS_LANE_W-1:0] pick;
  logic                   found;
  logic                   accept;

  // First non-full lane at or after the pointer
  always_comb begin
    logic [`BFS_LANE_W-1:0] cand;
    found = 1'b0;
    pick  = ptr;
    for (int k = 0; k < `BFS_NUM_LANES; k++) begin
      cand = ptr + k[`BFS_LANE_W-1:0];
      if (!found && !lane_full[cand]) begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  assign frontier_full = ~found;
  assign accept        = found & (|enq.req);

  // Steer the row to the picked lane, idle lanes see zero data
  always_comb begin
    for (int i = 0; i < `BFS_NUM_LANES; i++) begin
      if (accept && (pick == i[`BFS_LANE_W-1:0])) begin
        lane_enqueue_req[i] = enq.req;
        lane_wdata[i].raw   = enq.row.raw;
      end else begin
        lane_enqueue_req[i] = 2'b00;
        lane_wdata[i].raw   = '0;
      end
    end
  end

  // Pointer moves one past the lane used
  always_ff @(posedge clk) begin
    if (bfs_rst) begin
      ptr <= '0;
    end else if (accept) begin
      ptr <= pick + 1'b1;
    end
  end

endmodule

/* src/frontier_drain.sv */
// ########################################
// Round-robin drain and output register
// ########################################
`include "bfs_consts.svh"

module frontier_drain (
  input  logic                                               clk,
  input  logic                                               bfs_rst,
  input  bfs_lane_pkg::lane_status_t [`BFS_NUM_LANES-1:0]    lane_status,
  input  bfs_vertex_pkg::frontier_row_u [`BFS_NUM_LANES-1:0] lane_rdata,
  output logic [`BFS_NUM_LANES-1:0]                          dequeue_req,
  output logic                                               out_valid,
  output bfs_lane_pkg::drain_out_t                           out
);

  logic [`BFS_LANE_W-1:0] ptr;
  logic [`BFS_LANE_W-1:0] pick;
  logic                   found;
  logic                   taken;

  // First non-empty lane at or after the pointer
  always_comb begin
    logic [`BFS_LANE_W-1:0] cand;
    found = 1'b0;
    pick  = ptr;
    for (int k = 0; k < `BFS_NUM_LANES; k++) begin
      cand = ptr + k[`BFS_LANE_W-1:0];
      if (!found && !lane_status[cand].empty) begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  // One-hot request to the picked lane
  always_comb begin
    dequeue_req = '0;
    if (found) begin
      dequeue_req[pick] = 1'b1;
    end
  end

  // Lane may hold off while its half row is being completed
  assign taken = found & lane_status[pick].taken;

  always_ff @(posedge clk) begin
    if (bfs_rst) begin
      out_valid <= 1'b0;
      ptr       <= '0;
    end else begin
      out_valid <= taken;
      if (taken) begin
        ptr <= pick + 1'b1;
      end
    end
  end

  // Output payload
  always_ff @(posedge clk) begin
    if (taken) begin
      out.lane  <= pick;
      out.count <= lane_status[pick].filled ? 2'd2 : 2'd1;
      out.row   <= lane_rdata[pick];
    end
  end

endmodule

/* src/frontier_top.sv */
// ########################################
// Dispatcher, lane queues and drain
// ########################################
`include "bfs_consts.svh"

module frontier_top (
  input  logic                     clk,
  input  logic                     bfs_rst,
  input  bfs_lane_pkg::enq_row_t   enq,
  output logic                     frontier_full,
  output logic                     out_valid,
  output bfs_lane_pkg::drain_out_t out
);

  logic [`BFS_NUM_LANES-1:0][1:0]                     lane_enqueue_req;
  bfs_vertex_pkg::frontier_row_u [`BFS_NUM_LANES-1:0] lane_wdata;
  bfs_vertex_pkg::frontier_row_u [`BFS_NUM_LANES-1:0] lane_rdata;
  bfs_lane_pkg::lane_status_t [`BFS_NUM_LANES-1:0]    lane_status;
  logic [`BFS_NUM_LANES-1:0]                          lane_full;
  logic [`BFS_NUM_LANES-1:0]                          dequeue_req;

  frontier_dispatch u_dispatch (
    .clk              (clk),
    .bfs_rst          (bfs_rst),
    .enq              (enq),
    .lane_full        (lane_full),
    .lane_enqueue_req (lane_enqueue_req),
    .lane_wdata       (lane_wdata),
    .frontier_full    (frontier_full)
  );

  for (genvar i = 0; i < `BFS_NUM_LANES; i++) begin : g_lane
    queue_out u_queue (
      .clk         (clk),
      .bfs_rst     (bfs_rst),
      .enqueue_req (lane_enqueue_req[i]),
      .wdata_in    (lane_wdata[i]),
      .dequeue_req (dequeue_req[i]),
      .rdata_out   (lane_rdata[i]),
      .status      (lane_status[i])
    );
    assign lane_full[i] = lane_status[i].full;
  end

  frontier_drain u_drain (
    .clk         (clk),
    .bfs_rst     (bfs_rst),
    .lane_status (lane_status),
    .lane_rdata  (lane_rdata),
    .dequeue_req (dequeue_req),
    .out_valid   (out_valid),
    .out         (out)
  );

endmodule

/* dv/frontier_props.sv */
// ########################################
// Concurrent checks bound into frontier_top
// ########################################
`include "bfs_consts.svh"

module frontier_props (
  input logic                                 clk,
  input logic                                 bfs_rst,
  input logic [`BFS_NUM_LANES-1:0]            dequeue_req,
  input logic                                 out_valid,
  input bfs_lane_pkg::drain_out_t             out,
  input logic [`BFS_NUM_LANES-1:0][1:0]       lane_enqueue_req,
  input logic [`BFS_NUM_LANES-1:0]            lane_full
);

  // At most one lane asked to dequeue
  assert property (@(posedge clk) disable iff (bfs_rst) $onehot0(dequeue_req))
    else $error("dequeue_req has more than one bit set");

  assert property (@(posedge clk) disable iff (bfs_rst)
    out_valid |-> (out.count == 2'd1 || out.count == 2'd2))
    else $error("out.count outside 1..2");

  assert property (@(posedge clk) bfs_rst |=> !out_valid)
    else $error("out_valid high right after reset");

  // Dispatcher must skip full lanes
  for (genvar i = 0; i < `BFS_NUM_LANES; i++) begin : g_full
    assert property (@(posedge clk) disable iff (bfs_rst)
      lane_full[i] |-> (lane_enqueue_req[i] == 2'b00))
      else $error("enqueue into full lane %0d", i);
  end

endmodule

bind frontier_top frontier_props u_props (.*);

/* dv/frontier_tb.sv */
// ########################################
// Directed tests and per-lane reference model
// ########################################
`include "bfs_consts.svh"

module frontier_tb;

  localparam int NL = `BFS_NUM_LANES;

  logic                     clk;
  logic                     bfs_rst;
  bfs_lane_pkg::enq_row_t   enq;
  logic                     frontier_full;
  logic                     out_valid;
  bfs_lane_pkg::drain_out_t out;

  // Expected ids per lane with the oldest first
  logic [31:0] model_q [NL][$];
  int          model_ptr;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          ids_sent;
  int          ids_out;
  bit          pairs_only;
  integer      seed;
  string       test_name;

  frontier_top UUT (
    .clk           (clk),
    .bfs_rst       (bfs_rst),
    .enq           (enq),
    .frontier_full (frontier_full),
    .out_valid     (out_valid),
    .out           (out)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Output monitor sampled mid-cycle where out is stable
  always @(negedge clk) begin
    logic [31:0] exp_id;
    int          l;
    if (!bfs_rst && out_valid) begin
      l = int'(out.lane);
      ids_out += int'(out.count);
      if (pairs_only) begin
        assert (out.count == 2'd2) else begin
          $display("FAILED %s: expected count 2, actual %0d", test_name, out.count);
          errors++;
        end
      end
      assert (model_q[l].size() >= int'(out.count)) else begin
        $display("%s: lane %0d emitted a row with no ids left to expect", test_name, l);
        errors++;
      end
      if (model_q[l].size() >= int'(out.count) && out.count != 2'd0) begin
        exp_id = model_q[l].pop_front();
        assert (out.row.pair.lo == exp_id) else begin
          $display("FAILED %s: expected %h, actual %h", test_name, exp_id, out.row.pair.lo);
          errors++;
        end
        if (out.count == 2'd2) begin
          exp_id = model_q[l].pop_front();
          assert (out.row.pair.hi == exp_id) else begin
            $display("FAILED %s: expected %h, actual %h", test_name, exp_id,
                     out.row.pair.hi);
            errors++;
          end
        end
      end
    end
  end

  // Rows ahead of the tail row, the lane is full when only the spare row is left
  function automatic bit lane_near_full(input int l);
    return (model_q[l].size() / 2) >= (`BFS_Q_SIZE - 1);
  endfunction

  // First non-full lane at or after the pointer
  function automatic int pick_lane();
    int cand;
    for (int k = 0; k < NL; k++) begin
      cand = (model_ptr + k) % NL;
      if (!lane_near_full(cand)) begin
        return cand;
      end
    end
    return -1;
  endfunction

  task automatic model_push(input logic [1:0] req, input logic [31:0] hi, input logic [31:0] lo);
    int l;
    l = pick_lane();
    if (l < 0) begin
      $display("%s: row accepted while the model sees every lane full", test_name);
      errors++;
    end else begin
      model_q[l].push_back(lo);
      ids_sent++;
      if (req == 2'b11) begin
        model_q[l].push_back(hi);
        ids_sent++;
      end
      model_ptr = (l + 1) % NL;
    end
  endtask

  // Present a row and hold it until accepted
  task automatic send_row(input logic [1:0] req, input logic [31:0] hi, input logic [31:0] lo);
    int tries;
    bit accepted;
    tries    = 0;
    accepted = 1'b0;
    while (!accepted && tries < 200) begin
      @(posedge clk);
      #1;
      enq.req          = req;
      enq.row.pair.hi  = hi;
      enq.row.pair.lo  = lo;
      @(negedge clk);
      #1;
      accepted = !frontier_full;
      if (accepted) begin
        model_push(req, hi, lo);
      end
      tries++;
    end
    if (!accepted) begin
      $display("%s: row never accepted, frontier_full stuck high", test_name);
      errors++;
    end
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #1;
    enq = '0;
  endtask

  task automatic wait_drained(input int limit);
    int cycles;
    int left;
    cycles = 0;
    left   = 1;
    while (left != 0 && cycles < limit) begin
      @(negedge clk);
      #1;
      left = 0;
      for (int l = 0; l < NL; l++) begin
        left += model_q[l].size();
      end
      cycles++;
    end
    if (left != 0) begin
      $display("%s: timeout, %0d ids never came out", test_name, left);
      errors++;
    end
    // Let the monitor catch stray rows
    repeat (3) @(negedge clk);
    #1;
    assert (ids_out == ids_sent) else begin
      $display("FAILED %s: expected %0d ids, actual %0d", test_name, ids_sent, ids_out);
      errors++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    bfs_rst = 1'b1;
    enq     = '0;
    repeat (2) @(posedge clk);
    #1;
    bfs_rst = 1'b0;
    for (int l = 0; l < NL; l++) begin
      model_q[l].delete();
    end
    model_ptr = 0;
    ids_sent  = 0;
    ids_out   = 0;
  endtask

  task automatic report_test(input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("Test %s: FAIL (%0d errors)", test_name, errors - err_before);
    end else begin
      $display("Test %s: PASS", test_name);
    end
  endtask

  task automatic test_pairs_round_robin();
    int e0;
    e0         = errors;
    test_name  = "pairs_round_robin";
    pairs_only = 1'b1;
    for (int i = 0; i < 8; i++) begin
      send_row(2'b11, 32'h1000 + 2 * i + 1, 32'h1000 + 2 * i);
    end
    drive_idle();
    wait_drained(100);
    pairs_only = 1'b0;
    report_test(e0);
  endtask

  task automatic test_single_merge();
    int e0;
    e0        = errors;
    test_name = "single_merge";
    for (int i = 0; i < 24; i++) begin
      send_row(2'b01, 32'h0, 32'h2000 + i);
    end
    drive_idle();
    wait_drained(100);
    report_test(e0);
  endtask

  task automatic test_mixed_random();
    int e0;
    int kind;
    e0        = errors;
    test_name = "mixed_random";
    for (int i = 0; i < 60; i++) begin
      kind = $random(seed) & 3;
      if (kind == 0) begin
        drive_idle();
      end else if (kind == 1) begin
        send_row(2'b01, 32'h0, $random(seed));
      end else begin
        send_row(2'b11, $random(seed), $random(seed));
      end
    end
    drive_idle();
    wait_drained(200);
    report_test(e0);
  endtask

  task automatic test_full_backpressure();
    int e0;
    e0          = errors;
    test_name   = "full_backpressure";
    for (int i = 0; i < 64; i++) begin
      send_row(2'b11, 32'h3000 + 2 * i + 1, 32'h3000 + 2 * i);
    end
    drive_idle();
    wait_drained(300);
    assert (!frontier_full) else begin
      $display("%s: frontier_full still high after draining", test_name);
      errors++;
    end
    report_test(e0);
  endtask

  task automatic test_reset_state();
    int e0;
    e0        = errors;
    test_name = "reset_state";
    // Rows still in the lanes when reset hits
    for (int i = 0; i < 4; i++) begin
      send_row(2'b11, 32'h4000 + 2 * i + 1, 32'h4000 + 2 * i);
    end
    apply_reset();
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      assert (!out_valid) else begin
        $display("%s: out_valid high with no input after reset", test_name);
        errors++;
      end
      assert (!frontier_full) else begin
        $display("%s: frontier_full high after reset", test_name);
        errors++;
      end
    end
    report_test(e0);
  endtask

  initial begin
    seed         = 44;
    bfs_rst      = 1'b1;
    enq          = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    ids_sent     = 0;
    ids_out      = 0;
    pairs_only   = 1'b0;
    model_ptr    = 0;
    test_name    = "init";
    apply_reset();
    test_pairs_round_robin();
    test_single_merge();
    test_mixed_random();
    test_full_backpressure();
    test_reset_state();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Overall limit on run time
  initial begin
    #200000;
    $display("Global timeout, the run did not finish");
    $display("Simulation failed");
    $finish;
  end

endmodule

/* sources.f */
+incdir+src
src/bfs_vertex_pkg.sv
src/bfs_lane_pkg.sv
src/queue_out.sv
src/frontier_dispatch.sv
src/frontier_drain.sv
src/frontier_top.sv
dv/frontier_props.sv
dv/frontier_tb.sv

/* Makefile */
# Verilator build and run for the BFS frontier buffer

TOP     = frontier_tb
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o $(TOP)_sim

run: compile
	./$(OBJ_DIR)/$(TOP)_sim > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
